/* all.f */
rtl/ics32_pkg.sv
rtl/address_decoder.sv
rtl/bus_arbiter.sv
rtl/cpu_ram.sv
rtl/dsp_status_regs.sv
rtl/cpu_irq_control.sv
rtl/ics32_periph.sv
testbench/tb_ics32_periph.sv

/* run.sh */
#!/bin/sh
# build and run the peripheral fabric testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
    --top-module tb_ics32_periph \
    -f all.f \
    -o tb_ics32_periph_sim

./obj_dir/tb_ics32_periph_sim > sim.log 2>&1
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
exit 0

/* testbench/tb_ics32_periph.sv */
// ------------------------------------------------------------
// testbench for the cpu peripheral fabric
// acts as the picorv32 bus master, keeps a shadow model of
// ram, dsp operands, status and irq bits, checks every read
// ------------------------------------------------------------

`default_nettype none

module tb_ics32_periph;
    timeunit 1ns;
    timeprecision 1ps;

    logic vdp_clk;
    logic vdp_reset;
    logic mem_valid;
    logic [ics32_pkg::addr_width-1:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [3:0] mem_wstrb;
    logic frame_ended;
    logic raster_hit;
    wire mem_ready;
    wire [31:0] mem_rdata;
    wire [ics32_pkg::irq_count-1:0] irq;
    wire led_r;
    wire led_b;

    // shadow state of the fabric
    logic [31:0] shadow_ram [ics32_pkg::ram_words];
    logic [15:0] shadow_a;
    logic [15:0] shadow_b;
    logic [1:0] shadow_status;
    logic [1:0] shadow_pending;

    logic read_check;
    logic [31:0] expected_word;
    logic [23:0] expected_addr;
    integer seed = 92367;
    integer check_count = 0;
    integer reads_issued = 0;
    integer read_mismatches = 0;
    integer signal_mismatches = 0;
    integer failures = 0;

    ics32_periph dut0 (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .mem_valid(mem_valid),
        .mem_addr(mem_addr),
        .mem_wdata(mem_wdata),
        .mem_wstrb(mem_wstrb),
        .frame_ended(frame_ended),
        .raster_hit(raster_hit),
        .mem_ready(mem_ready),
        .mem_rdata(mem_rdata),
        .irq(irq),
        .led_r(led_r),
        .led_b(led_b)
    );

    function automatic logic [23:0] ram_addr(input logic [10:0] word);
        return {ics32_pkg::ram_region, 7'h0, word, 2'b00};
    endfunction

    function automatic logic [31:0] model_read(input logic [23:0] addr);
        logic signed [15:0] op_a;
        logic signed [15:0] op_b;
        logic signed [31:0] product;
        logic [31:0] word;
        op_a = shadow_a;
        op_b = shadow_b;
        product = op_a * op_b;
        case (addr[23:20])
            ics32_pkg::ram_region:    word = shadow_ram[addr[12:2]];
            ics32_pkg::status_region: word = {30'h0, shadow_status};
            ics32_pkg::dsp_region:    word = product;
            ics32_pkg::irq_region:    word = {30'h0, shadow_pending};
            default:                  word = 32'h0;
        endcase
        return word;
    endfunction

    function automatic void update_model(input logic [23:0] addr, input logic [31:0] data,
            input logic [3:0] strb);
        case (addr[23:20])
            ics32_pkg::ram_region: begin
                for (int lane = 0; lane < 4; lane++) begin
                    if (strb[lane]) begin
                        shadow_ram[addr[12:2]][lane*8 +: 8] = data[lane*8 +: 8];
                    end
                end
            end
            ics32_pkg::status_region: shadow_status = data[1:0];
            ics32_pkg::dsp_region: begin
                if (addr[2]) begin
                    shadow_b = data[15:0];
                end else begin
                    shadow_a = data[15:0];
                end
            end
            ics32_pkg::irq_region: shadow_pending = shadow_pending & ~data[1:0];
            default: ;
        endcase
    endfunction

    // called right after a falling edge
    task automatic run_access(input logic [23:0] addr, input logic [31:0] data,
            input logic [3:0] strb);
        int cycles;
        cycles = 0;
        if (strb == 4'b0000) begin
            expected_word = model_read(addr);
            expected_addr = addr;
            read_check = 1'b1;
        end
        mem_addr = addr;
        mem_wdata = data;
        mem_wstrb = strb;
        mem_valid = 1'b1;
        while (!mem_ready && cycles < 20) begin
            @(negedge vdp_clk);
            cycles++;
        end
        if (!mem_ready) begin
            failures++;
            $display("timeout: no mem_ready within 20 cycles for address 0x%06h", addr);
        end else begin
            // ready is seen at E2, two cycles after valid is first sampled
            assert (cycles == 2) else begin
                signal_mismatches++;
                $display("mismatch mem_ready latency: got 0x%0h expected 0x2", cycles);
            end
        end
        // valid stays up through the edge that samples ready
        @(negedge vdp_clk);
        mem_valid = 1'b0;
        mem_wstrb = 4'b0000;
        read_check = 1'b0;
        if (strb != 4'b0000) begin
            update_model(addr, data, strb);
        end
        @(negedge vdp_clk);
    endtask

    task automatic write_word(input logic [23:0] addr, input logic [31:0] data,
            input logic [3:0] strb);
        run_access(addr, data, strb);
    endtask

    task automatic read_word(input logic [23:0] addr);
        reads_issued++;
        run_access(addr, 32'h0, 4'b0000);
    endtask

    task automatic pulse_event(input logic [1:0] which);
        frame_ended = which[0];
        raster_hit = which[1];
        @(negedge vdp_clk);
        frame_ended = 1'b0;
        raster_hit = 1'b0;
        shadow_pending = shadow_pending | which;
        @(negedge vdp_clk);
    endtask

    task automatic check_outputs();
        assert (led_r === shadow_status[0]) else begin
            signal_mismatches++;
            $display("mismatch led_r: got 0x%0h expected 0x%0h", led_r, shadow_status[0]);
        end
        assert (led_b === shadow_status[1]) else begin
            signal_mismatches++;
            $display("mismatch led_b: got 0x%0h expected 0x%0h", led_b, shadow_status[1]);
        end
        assert (irq === shadow_pending) else begin
            signal_mismatches++;
            $display("mismatch irq: got 0x%0h expected 0x%0h", irq, shadow_pending);
        end
    endtask

    initial begin
        vdp_clk = 1'b0;
        forever #5 vdp_clk = ~vdp_clk;
    end

    // read data compare, once per ready pulse
    always @(negedge vdp_clk) begin
        if (mem_ready && read_check) begin
            check_count++;
            assert (mem_rdata === expected_word) else begin
                read_mismatches++;
                $display("mismatch mem_rdata at 0x%06h: got 0x%08h expected 0x%08h",
                    expected_addr, mem_rdata, expected_word);
            end
        end
    end

    initial begin
        logic [10:0] words [16];
        logic [3:0] idx;
        logic [3:0] strb;
        vdp_reset = 1'b1;
        mem_valid = 1'b0;
        mem_addr = '0;
        mem_wdata = 32'h0;
        mem_wstrb = 4'b0000;
        frame_ended = 1'b0;
        raster_hit = 1'b0;
        shadow_a = 16'h0;
        shadow_b = 16'h0;
        shadow_status = 2'b01;
        shadow_pending = 2'b00;
        read_check = 1'b0;
        expected_word = 32'h0;
        expected_addr = 24'h0;
        repeat (4) @(negedge vdp_clk);
        vdp_reset = 1'b0;
        @(negedge vdp_clk);

        // state out of reset
        check_outputs();
        read_word({ics32_pkg::status_region, 20'h0});

        // full words first so no lane stays unknown
        for (int i = 0; i < 16; i++) begin
            words[i] = 11'($random(seed));
            write_word(ram_addr(words[i]), $random(seed), 4'hf);
        end
        for (int i = 0; i < 48; i++) begin
            idx = 4'($random(seed));
            strb = 4'($random(seed));
            if (strb == 4'b0000) begin
                strb = 4'b1000;
            end
            write_word(ram_addr(words[idx]), $random(seed), strb);
        end
        for (int i = 0; i < 16; i++) begin
            read_word(ram_addr(words[i]));
        end

        // signed multiplier
        for (int i = 0; i < 8; i++) begin
            write_word({ics32_pkg::dsp_region, 20'h0}, $random(seed), 4'hf);
            write_word({ics32_pkg::dsp_region, 20'h4}, $random(seed), 4'hf);
            read_word({ics32_pkg::dsp_region, 20'h0});
        end

        // status leds
        for (int v = 0; v < 4; v++) begin
            write_word({ics32_pkg::status_region, 20'h0}, {30'($random(seed)), 2'(v)}, 4'hf);
            check_outputs();
            read_word({ics32_pkg::status_region, 20'h0});
        end

        // interrupt set and acknowledge
        pulse_event(2'b01);
        check_outputs();
        read_word({ics32_pkg::irq_region, 20'h0});
        pulse_event(2'b10);
        check_outputs();
        read_word({ics32_pkg::irq_region, 20'h0});
        write_word({ics32_pkg::irq_region, 20'h0}, 32'h1, 4'hf);
        check_outputs();
        read_word({ics32_pkg::irq_region, 20'h0});
        pulse_event(2'b01);
        write_word({ics32_pkg::irq_region, 20'h0}, 32'h0, 4'hf);
        check_outputs();
        write_word({ics32_pkg::irq_region, 20'h0}, 32'hffff_fffe, 4'hf);
        check_outputs();
        read_word({ics32_pkg::irq_region, 20'h0});
        write_word({ics32_pkg::irq_region, 20'h0}, 32'h3, 4'hf);
        check_outputs();
        read_word({ics32_pkg::irq_region, 20'h0});

        // unmapped regions, low bits alias a live ram word
        write_word({4'h7, 7'h0, words[0], 2'b00}, $random(seed), 4'hf);
        write_word({4'h9, 20'h4}, 32'h3, 4'hf);
        read_word({4'h7, 7'h0, words[0], 2'b00});
        read_word({4'hf, 20'h4});
        read_word(ram_addr(words[0]));
        read_word({ics32_pkg::status_region, 20'h0});
        read_word({ics32_pkg::dsp_region, 20'h0});
        read_word({ics32_pkg::irq_region, 20'h0});
        check_outputs();

        if (check_count != reads_issued) begin
            failures++;
            $display("only %0d of %0d reads were compared", check_count, reads_issued);
        end
        $display("checks %0d, read mismatches %0d, signal mismatches %0d, failures %0d",
            check_count, read_mismatches, signal_mismatches, failures);
        if (read_mismatches + signal_mismatches + failures == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/ics32_periph.sv */
// ---------------------------------------------------------
// cpu side peripheral fabric on the picorv32 memory bus
// decoder, arbiter, work ram, dsp/status regs and irqs
// ---------------------------------------------------------

`default_nettype none

module ics32_periph (
    input  wire                                 vdp_clk,
    input  wire                                 vdp_reset,
    input  wire                                 mem_valid,
    input  wire [ics32_pkg::addr_width-1:0]     mem_addr,
    input  wire [31:0]                          mem_wdata,
    input  wire [3:0]                           mem_wstrb,
    input  wire                                 frame_ended,
    input  wire                                 raster_hit,
    output logic                                mem_ready,
    output logic [31:0]                         mem_rdata,
    output logic [ics32_pkg::irq_count-1:0]     irq,
    output logic                                led_r,
    output logic                                led_b
);
    ics32_pkg::region_t region_sel;
    logic ram_en;
    logic ram_write_en;
    logic status_write_en;
    logic dsp_write_en;
    logic irq_write_en;

    logic [$clog2(ics32_pkg::ram_words)-1:0] ram_address;
    logic ram_cs;
    logic [3:0] ram_wstrb;
    logic [31:0] ram_write_data;
    logic [31:0] ram_read_data;

    logic [31:0] dsp_result;
    logic [1:0] status;
    logic [ics32_pkg::irq_count-1:0] irq_pending;

    address_decoder decoder (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .mem_valid(mem_valid),
        .mem_addr(mem_addr),
        .mem_wstrb(mem_wstrb),
        .mem_ready(mem_ready),
        .region_sel(region_sel),
        .ram_en(ram_en),
        .ram_write_en(ram_write_en),
        .status_write_en(status_write_en),
        .dsp_write_en(dsp_write_en),
        .irq_write_en(irq_write_en)
    );

    bus_arbiter arbiter (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .region_sel(region_sel),
        .ram_en(ram_en),
        .mem_addr(mem_addr),
        .mem_wdata(mem_wdata),
        .mem_wstrb(mem_wstrb),
        .ram_read_data(ram_read_data),
        .dsp_result(dsp_result),
        .status(status),
        .irq_pending(irq_pending),
        .ram_address(ram_address),
        .ram_cs(ram_cs),
        .ram_wstrb(ram_wstrb),
        .ram_write_data(ram_write_data),
        .mem_rdata(mem_rdata)
    );

    cpu_ram ram (
        .vdp_clk(vdp_clk),
        .address(ram_address),
        .cs(ram_cs),
        .wstrb(ram_wstrb),
        .write_data(ram_write_data),
        .read_data(ram_read_data)
    );

    dsp_status_regs regs (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .dsp_write_en(dsp_write_en),
        .status_write_en(status_write_en),
        .mem_addr(mem_addr),
        .mem_wdata(mem_wdata),
        .dsp_result(dsp_result),
        .status(status)
    );

    cpu_irq_control irq_control (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .frame_ended(frame_ended),
        .raster_hit(raster_hit),
        .irq_write_en(irq_write_en),
        .mem_wdata(mem_wdata),
        .irq_pending(irq_pending),
        .irq(irq)
    );

    assign led_r = status[0];
    assign led_b = status[1];

    // a decoded ram write still addresses the ram with live strobes
    ram_write_path: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        ram_write_en |-> (ram_cs && |ram_wstrb));

endmodule

`default_nettype wire

/* rtl/cpu_irq_control.sv */
// ---------------------------------------------------------
// interrupt controller for frame end and raster hit
// rising edges set pending bits, cpu writes of ones clear
// ---------------------------------------------------------

`default_nettype none

module cpu_irq_control (
    input  wire                                 vdp_clk,
    input  wire                                 vdp_reset,
    input  wire                                 frame_ended,
    input  wire                                 raster_hit,
    input  wire                                 irq_write_en,
    input  wire [31:0]                          mem_wdata,
    output logic [ics32_pkg::irq_count-1:0]     irq_pending,
    output logic [ics32_pkg::irq_count-1:0]     irq
);
    logic [ics32_pkg::irq_count-1:0] source;
    logic [ics32_pkg::irq_count-1:0] source_q;
    logic [ics32_pkg::irq_count-1:0] rising;
    logic [ics32_pkg::irq_count-1:0] ack_mask;

    // bit 0 frame, bit 1 raster
    assign source = {raster_hit, frame_ended};
    assign rising = source & ~source_q;

    assign ack_mask = irq_write_en ? mem_wdata[ics32_pkg::irq_count-1:0]
        : '0;

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            source_q <= '0;
            irq_pending <= '0;
        end else begin
            source_q <= source;
            // a fresh edge beats a clear in the same cycle
            irq_pending <= (irq_pending & ~ack_mask) | rising;
        end
    end

    // level interrupts straight from the pending bits
    assign irq = irq_pending;

endmodule

`default_nettype wire

/* rtl/dsp_status_regs.sv */
// ---------------------------------------------------------
// memory mapped 16x16 signed multiplier and the two bit
// status register that lights the board leds
// ---------------------------------------------------------

`default_nettype none

module dsp_status_regs (
    input  wire                                 vdp_clk,
    input  wire                                 vdp_reset,
    input  wire                                 dsp_write_en,
    input  wire                                 status_write_en,
    input  wire [ics32_pkg::addr_width-1:0]     mem_addr,
    input  wire [31:0]                          mem_wdata,
    output logic [31:0]                         dsp_result,
    output logic [1:0]                          status
);
    logic [15:0] dsp_mult_a;
    logic [15:0] dsp_mult_b;

    // address bit 2 picks operand b
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            dsp_mult_a <= 16'h0;
            dsp_mult_b <= 16'h0;
        end else begin
            if (dsp_write_en && !mem_addr[2]) begin
                dsp_mult_a <= mem_wdata[15:0];
            end
            if (dsp_write_en && mem_addr[2]) begin
                dsp_mult_b <= mem_wdata[15:0];
            end
        end
    end

    // product follows the operands one cycle later
    always_ff @(posedge vdp_clk) begin
        dsp_result <= $signed(dsp_mult_a) * $signed(dsp_mult_b);
    end

    // red led on out of reset
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            status <= 2'b01;
        end else if (status_write_en) begin
            status <= mem_wdata[1:0];
        end
    end

endmodule

`default_nettype wire

/* rtl/cpu_ram.sv */
// ---------------------------------------------------------
// cpu work ram, one 32 bit word per address
// byte lanes written by strobe, read data registered
// ---------------------------------------------------------

`default_nettype none

module cpu_ram (
    input  wire                                         vdp_clk,
    input  wire [$clog2(ics32_pkg::ram_words)-1:0]      address,
    input  wire                                         cs,
    input  wire [3:0]                                   wstrb,
    input  wire [31:0]                                  write_data,
    output logic [31:0]                                 read_data
);
    logic [31:0] mem [ics32_pkg::ram_words];

    always_ff @(posedge vdp_clk) begin
        if (cs) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (wstrb[lane]) begin
                    mem[address][lane*8 +: 8] <= write_data[lane*8 +: 8];
                end
            end

            // read returns the word before this cycle's write
            read_data <= mem[address];
        end
    end

endmodule

`default_nettype wire

/* rtl/bus_arbiter.sv */
// ---------------------------------------------------------
// drives the cpu ram port from the bus and returns the
// read word of the region that the decoder selected
// ---------------------------------------------------------

`default_nettype none

module bus_arbiter (
    input  wire                                         vdp_clk,
    input  wire                                         vdp_reset,
    input  wire ics32_pkg::region_t                     region_sel,
    input  wire                                         ram_en,
    input  wire [ics32_pkg::addr_width-1:0]             mem_addr,
    input  wire [31:0]                                  mem_wdata,
    input  wire [3:0]                                   mem_wstrb,
    input  wire [31:0]                                  ram_read_data,
    input  wire [31:0]                                  dsp_result,
    input  wire [1:0]                                   status,
    input  wire [ics32_pkg::irq_count-1:0]              irq_pending,
    output logic [$clog2(ics32_pkg::ram_words)-1:0]     ram_address,
    output logic                                        ram_cs,
    output logic [3:0]                                  ram_wstrb,
    output logic [31:0]                                 ram_write_data,
    output logic [31:0]                                 mem_rdata
);
    logic [31:0] read_word;

    // word address, byte offset dropped
    assign ram_address = mem_addr[$clog2(ics32_pkg::ram_words)+1:2];

    // ram reads whenever the address points into it,
    // so its word is ready one cycle before the region enable
    assign ram_cs = (mem_addr[ics32_pkg::region_msb:ics32_pkg::region_lsb]
        == ics32_pkg::ram_region);

    assign ram_wstrb = ram_en ? mem_wstrb : 4'b0000;
    assign ram_write_data = mem_wdata;

    always_comb begin
        case (region_sel)
            ics32_pkg::region_ram:    read_word = ram_read_data;
            ics32_pkg::region_status: read_word = 32'(status);
            ics32_pkg::region_dsp:    read_word = dsp_result;
            ics32_pkg::region_irq:    read_word = 32'(irq_pending);
            default:                  read_word = 32'h0;
        endcase
    end

    // captured at E1 and held through the ready cycle
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            mem_rdata <= 32'h0;
        end else begin
            mem_rdata <= read_word;
        end
    end

endmodule

`default_nettype wire

/* rtl/address_decoder.sv */
// ---------------------------------------------------------
// bus access FSM for the picorv32 memory interface
// classifies each access, pulses one region enable and
// answers with mem_ready two cycles after valid is seen
// ---------------------------------------------------------

`default_nettype none

module address_decoder (
    input  wire                                 vdp_clk,
    input  wire                                 vdp_reset,
    input  wire                                 mem_valid,
    input  wire [ics32_pkg::addr_width-1:0]     mem_addr,
    input  wire [3:0]                           mem_wstrb,
    output logic                                mem_ready,
    output ics32_pkg::region_t                  region_sel,
    output logic                                ram_en,
    output logic                                ram_write_en,
    output logic                                status_write_en,
    output logic                                dsp_write_en,
    output logic                                irq_write_en
);
    ics32_pkg::decode_state_t state;
    ics32_pkg::region_t region_next;
    logic write_q;
    logic access;

    always_comb begin
        case (mem_addr[ics32_pkg::region_msb:ics32_pkg::region_lsb])
            ics32_pkg::ram_region:    region_next = ics32_pkg::region_ram;
            ics32_pkg::status_region: region_next = ics32_pkg::region_status;
            ics32_pkg::dsp_region:    region_next = ics32_pkg::region_dsp;
            ics32_pkg::irq_region:    region_next = ics32_pkg::region_irq;
            default:                  region_next = ics32_pkg::region_none;
        endcase
    end

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            state <= ics32_pkg::state_idle;
            region_sel <= ics32_pkg::region_none;
            write_q <= 1'b0;
        end else begin
            case (state)
                ics32_pkg::state_idle: begin
                    // region and direction are held for the whole access
                    if (mem_valid) begin
                        region_sel <= region_next;
                        write_q <= |mem_wstrb;
                        state <= ics32_pkg::state_access;
                    end
                end
                ics32_pkg::state_access: begin
                    state <= ics32_pkg::state_respond;
                end
                ics32_pkg::state_respond: begin
                    state <= ics32_pkg::state_wait_release;
                end
                default: begin
                    // master must drop valid before the next access
                    if (!mem_valid) begin
                        state <= ics32_pkg::state_idle;
                    end
                end
            endcase
        end
    end

    assign access = (state == ics32_pkg::state_access);

    assign ram_en = access && (region_sel == ics32_pkg::region_ram);
    assign ram_write_en = ram_en && write_q;
    assign status_write_en = access && write_q && (region_sel == ics32_pkg::region_status);
    assign dsp_write_en = access && write_q && (region_sel == ics32_pkg::region_dsp);
    assign irq_write_en = access && write_q && (region_sel == ics32_pkg::region_irq);

    assign mem_ready = (state == ics32_pkg::state_respond);

    // ready only answers a pending request
    ready_needs_valid: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        mem_ready |-> mem_valid);

    // one ready pulse per access
    single_ready: assert property (@(posedge vdp_clk) disable iff (vdp_reset)
        (state == ics32_pkg::state_respond) |=> !mem_ready);

endmodule

`default_nettype wire

/* rtl/ics32_pkg.sv */
// ---------------------------------------------------------
// shared definitions for the CPU peripheral fabric
// address map, region codes and decoder state encoding
// referenced by scoped name from every RTL module
// ---------------------------------------------------------

`default_nettype none

package ics32_pkg;

    // cpu address bus
    localparam int addr_width = 24;

    // top nibble of the address picks the region
    localparam int region_msb = 23;
    localparam int region_lsb = 20;

    localparam logic [3:0] ram_region    = 4'd0;
    localparam logic [3:0] status_region = 4'd1;
    localparam logic [3:0] dsp_region    = 4'd2;
    localparam logic [3:0] irq_region    = 4'd3;

    // 8KB of cpu ram as 32 bit words
    localparam int ram_words = 2048;

    // frame end and raster hit
    localparam int irq_count = 2;

    typedef enum logic [2:0] {
        region_ram,
        region_status,
        region_dsp,
        region_irq,
        region_none
    } region_t;

    typedef enum logic [1:0] {
        state_idle,
        state_access,
        state_respond,
        state_wait_release
    } decode_state_t;

endpackage

`default_nettype wire
